// ==== axi_mem.f ====
+incdir+hw
hw/axi_mem_pkg.sv
hw/axi_mem_req_fifo.sv
hw/axi_mem_beat_counter.sv
hw/axi_mem_array.sv
hw/axi_mem_write_ctrl.sv
hw/axi_mem_read_ctrl.sv
hw/axi_mem_top.sv
testbench/tb_clock_gen.sv
testbench/tb_axi_mem.sv

// ==== Makefile ====
# Verilator build and run for the AXI memory testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_mem
FILELIST  ?= axi_mem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(OBJ_DIR)/V%: $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* --Mdir $(OBJ_DIR) -o V$*

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_axi_mem.sv ====
`default_nettype none

`include "axi_mem_consts.svh"

module tb_axi_mem;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_mem_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int WORDS = `AXI_MEM_WORDS;
  localparam int CH_AW = 0;
  localparam int CH_W = 1;
  localparam int CH_B = 2;
  localparam int CH_AR = 3;
  localparam int CH_R = 4;

  logic clk, rst;
  logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready, r_last;
  id_t aw_id, b_id, ar_id, r_id;
  addr_t aw_addr, ar_addr;
  len_t aw_len, ar_len;
  data_t w_data, r_data;
  strb_t w_strb;
  resp_t b_resp, r_resp;

  // Byte-level reference of everything the DUT accepted
  logic [7:0] model_bytes [WORDS*STRB_W];
  bit model_known [WORDS*STRB_W];

  // Values the next handshake on B or R must carry
  id_t exp_b_id, exp_r_id;
  resp_t exp_b_resp;
  data_t exp_r_data, exp_r_mask;
  logic exp_r_last;
  int b_due = 0;
  int r_beats_due = 0;
  logic [31:0] lcg_state = 32'h980c;

  tb_clock_gen clock_gen_inst (.clk_o(clk));

  axi_mem_top axi_mem_top_inst (
    .clk_i(clk), .rst_i(rst),
    .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_id_i(aw_id),
    .aw_addr_i(aw_addr), .aw_len_i(aw_len),
    .w_valid_i(w_valid), .w_ready_o(w_ready), .w_data_i(w_data),
    .w_strb_i(w_strb), .w_last_i(w_last),
    .b_valid_o(b_valid), .b_ready_i(b_ready), .b_id_o(b_id), .b_resp_o(b_resp),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_id_i(ar_id),
    .ar_addr_i(ar_addr), .ar_len_i(ar_len),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data), .r_id_o(r_id),
    .r_resp_o(r_resp), .r_last_o(r_last)
  );

  task automatic report_mismatch(input string what);
    $display("ERROR at %0d ns: %s", $time, what);
    $display("Verification failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Ready is high on about three cycles out of four
  function automatic logic ready_draw();
    logic [31:0] r;
    r = next_random();
    return r[17:16] != 2'b00;
  endfunction

  function automatic logic handshake_now(input int chan);
    case (chan)
      CH_AW:   return aw_valid && aw_ready;
      CH_W:    return w_valid && w_ready;
      CH_B:    return b_valid && b_ready;
      CH_AR:   return ar_valid && ar_ready;
      default: return r_valid && r_ready;
    endcase
  endfunction

  function automatic int word_of(input addr_t addr);
    return (int'(addr) / STRB_W) % WORDS;
  endfunction

  function automatic data_t expected_word(input int word, input bit mask_only);
    data_t value;
    int b;
    for (b = 0; b < STRB_W; b++) begin
      if (!model_known[word*STRB_W + b]) value[b*8 +: 8] = 8'h00;
      else value[b*8 +: 8] = mask_only ? 8'hff : model_bytes[word*STRB_W + b];
    end
    return value;
  endfunction

  // Entered at a falling edge with valid up and left at the falling edge after the transfer
  task automatic wait_handshake(input int chan, input string what);
    int cycles;
    cycles = 0;
    forever begin
      if (chan == CH_B) b_ready = ready_draw();
      if (chan == CH_R) r_ready = ready_draw();
      if (handshake_now(chan)) break;
      if (cycles == TIMEOUT_CYCLES) begin
        $display("Timed out waiting for the %s", what);
        $display("Verification failed");
        $fatal(1);
      end
      cycles++;
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic write_burst(input id_t id, input addr_t addr, input len_t len,
                             input int last_beat, input bit full_strobe);
    int word;
    int beat;
    int b;
    word = word_of(addr);
    aw_valid = 1'b1;
    aw_id = id;
    aw_addr = addr;
    aw_len = len;
    wait_handshake(CH_AW, "AW handshake");
    aw_valid = 1'b0;
    b_due++;
    for (beat = 0; beat <= int'(len); beat++) begin
      w_valid = 1'b1;
      w_data = next_random();
      w_strb = full_strobe ? '1 : strb_t'(next_random() >> 8);
      w_last = (beat == last_beat);
      for (b = 0; b < STRB_W; b++) begin
        if (w_strb[b]) begin
          model_bytes[word*STRB_W + b] = w_data[b*8 +: 8];
          model_known[word*STRB_W + b] = 1'b1;
        end
      end
      wait_handshake(CH_W, "W beat");
      word = (word + 1) % WORDS;
    end
    w_valid = 1'b0;
    w_last = 1'b0;
    exp_b_id = id;
    exp_b_resp = (last_beat == int'(len)) ? `AXI_MEM_RESP_OKAY : `AXI_MEM_RESP_SLVERR;
    wait_handshake(CH_B, "B response");
    b_due--;
  endtask

  task automatic send_ar(input id_t id, input addr_t addr, input len_t len);
    ar_valid = 1'b1;
    ar_id = id;
    ar_addr = addr;
    ar_len = len;
    wait_handshake(CH_AR, "AR handshake");
    ar_valid = 1'b0;
    r_beats_due += int'(len) + 1;
  endtask

  task automatic collect_read(input id_t id, input addr_t addr, input len_t len);
    int word;
    int beat;
    word = word_of(addr);
    exp_r_id = id;
    for (beat = 0; beat <= int'(len); beat++) begin
      exp_r_data = expected_word(word, 1'b0);
      exp_r_mask = expected_word(word, 1'b1);
      exp_r_last = (beat == int'(len));
      wait_handshake(CH_R, "R beat");
      r_beats_due--;
      word = (word + 1) % WORDS;
    end
    r_ready = 1'b0;
  endtask

  task automatic read_burst(input id_t id, input addr_t addr, input len_t len);
    send_ar(id, addr, len);
    collect_read(id, addr, len);
  endtask

  assert property (@(posedge clk) rst |=> !w_ready && !b_valid && !r_valid
    && aw_ready && ar_ready)
    else report_mismatch("handshake outputs not at their reset values");
  assert property (@(posedge clk) disable iff (rst)
    b_valid && b_ready |-> b_id == exp_b_id && b_resp == exp_b_resp)
    else report_mismatch($sformatf("B response, expected id %0h resp %0d",
      exp_b_id, exp_b_resp));
  assert property (@(posedge clk) disable iff (rst)
    r_valid && r_ready |-> ((r_data ^ exp_r_data) & exp_r_mask) == '0
      && r_id == exp_r_id && r_resp == `AXI_MEM_RESP_OKAY && r_last == exp_r_last)
    else report_mismatch($sformatf("R beat, expected data %h id %0h last %0b",
      exp_r_data, exp_r_id, exp_r_last));
  assert property (@(posedge clk) disable iff (rst)
    b_valid && !b_ready |=> b_valid && $stable(b_id) && $stable(b_resp))
    else report_mismatch("B payload changed while stalled");
  assert property (@(posedge clk) disable iff (rst)
    r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_id)
      && $stable(r_resp) && $stable(r_last))
    else report_mismatch("R payload changed while stalled");
  assert property (@(posedge clk) disable iff (rst) b_valid |-> b_due > 0)
    else report_mismatch("B response without an outstanding write");
  assert property (@(posedge clk) disable iff (rst) r_valid |-> r_beats_due > 0)
    else report_mismatch("R beat beyond the requested burst length");

  initial begin
    int i;
    int offset;
    logic [31:0] rnd;
    len_t len;
    rst = 1'b1;
    aw_valid = 1'b0;
    aw_id = '0;
    aw_addr = '0;
    aw_len = '0;
    w_valid = 1'b0;
    w_data = '0;
    w_strb = '0;
    w_last = 1'b0;
    b_ready = 1'b0;
    ar_valid = 1'b0;
    ar_id = '0;
    ar_addr = '0;
    ar_len = '0;
    r_ready = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Single beat write and read back
    write_burst(id_t'(3), addr_t'(16'h0040), len_t'(0), 0, 1'b1);
    read_burst(id_t'(5), addr_t'(16'h0040), len_t'(0));

    // Words 64 to 71 get known contents first
    write_burst(id_t'(1), addr_t'(16'h0100), len_t'(7), 7, 1'b1);
    write_burst(id_t'(2), addr_t'(16'h0104), len_t'(3), 3, 1'b0);
    read_burst(id_t'(6), addr_t'(16'h0104), len_t'(3));

    // w_last on the second of four beats
    write_burst(id_t'(7), addr_t'(16'h0100), len_t'(3), 1, 1'b0);
    read_burst(id_t'(8), addr_t'(16'h0100), len_t'(3));

    // Random lengths and unaligned starts inside the known window
    for (i = 0; i < 12; i++) begin
      rnd = next_random();
      len = len_t'(rnd[25:24]);
      offset = int'(rnd[20:16]) % 20;
      write_burst(id_t'(rnd[11:8]), addr_t'(256 + offset), len, int'(len), 1'b0);
      rnd = next_random();
      offset = int'(rnd[20:16]) % 20;
      read_burst(id_t'(rnd[11:8]), addr_t'(256 + offset), len_t'(rnd[25:24]));
    end

    // Four reads queued back to back
    for (i = 0; i < 4; i++) send_ar(id_t'(9 + i), addr_t'(256 + 4*i), len_t'(i));
    for (i = 0; i < 4; i++) collect_read(id_t'(9 + i), addr_t'(256 + 4*i), len_t'(i));

    repeat (4) @(negedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PERIOD_NS = 40;

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== hw/axi_mem_top.sv ====
`default_nettype none

module axi_mem_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  axi_mem_pkg::id_t    aw_id_i,
  input  axi_mem_pkg::addr_t  aw_addr_i,
  input  axi_mem_pkg::len_t   aw_len_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  axi_mem_pkg::data_t  w_data_i,
  input  axi_mem_pkg::strb_t  w_strb_i,
  input  logic                w_last_i,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output axi_mem_pkg::id_t    b_id_o,
  output axi_mem_pkg::resp_t  b_resp_o,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  axi_mem_pkg::id_t    ar_id_i,
  input  axi_mem_pkg::addr_t  ar_addr_i,
  input  axi_mem_pkg::len_t   ar_len_i,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output axi_mem_pkg::data_t  r_data_o,
  output axi_mem_pkg::id_t    r_id_o,
  output axi_mem_pkg::resp_t  r_resp_o,
  output logic                r_last_o
);
  import axi_mem_pkg::*;

  burst_req_t aw_req, aw_head, ar_req, ar_head;
  logic       aw_full, aw_empty, aw_pop;
  logic       ar_full, ar_empty, ar_pop;
  logic       mem_we, mem_re;
  word_addr_t mem_waddr, mem_raddr;
  data_t      mem_wdata, mem_rdata;
  strb_t      mem_wstrb;

  // Start address aligned down to a word, upper bits wrap
  assign aw_req.id        = aw_id_i;
  assign aw_req.word_addr = aw_addr_i[BYTE_OFF_W +: WORD_ADDR_W];
  assign aw_req.len       = aw_len_i;
  assign ar_req.id        = ar_id_i;
  assign ar_req.word_addr = ar_addr_i[BYTE_OFF_W +: WORD_ADDR_W];
  assign ar_req.len       = ar_len_i;

  assign aw_ready_o = !aw_full;
  assign ar_ready_o = !ar_full;

  axi_mem_req_fifo aw_fifo_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .push_i     (aw_valid_i && aw_ready_o),
    .push_data_i(aw_req),
    .full_o     (aw_full),
    .pop_i      (aw_pop),
    .head_o     (aw_head),
    .empty_o    (aw_empty)
  );

  axi_mem_req_fifo ar_fifo_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .push_i     (ar_valid_i && ar_ready_o),
    .push_data_i(ar_req),
    .full_o     (ar_full),
    .pop_i      (ar_pop),
    .head_o     (ar_head),
    .empty_o    (ar_empty)
  );

  axi_mem_write_ctrl write_ctrl_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_empty_i(aw_empty),
    .req_head_i (aw_head),
    .req_pop_o  (aw_pop),
    .w_valid_i  (w_valid_i),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_last_i   (w_last_i),
    .w_ready_o  (w_ready_o),
    .b_valid_o  (b_valid_o),
    .b_id_o     (b_id_o),
    .b_resp_o   (b_resp_o),
    .b_ready_i  (b_ready_i),
    .mem_we_o   (mem_we),
    .mem_waddr_o(mem_waddr),
    .mem_wdata_o(mem_wdata),
    .mem_wstrb_o(mem_wstrb)
  );

  axi_mem_read_ctrl read_ctrl_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_empty_i(ar_empty),
    .req_head_i (ar_head),
    .req_pop_o  (ar_pop),
    .r_valid_o  (r_valid_o),
    .r_data_o   (r_data_o),
    .r_id_o     (r_id_o),
    .r_resp_o   (r_resp_o),
    .r_last_o   (r_last_o),
    .r_ready_i  (r_ready_i),
    .mem_re_o   (mem_re),
    .mem_raddr_o(mem_raddr),
    .mem_rdata_i(mem_rdata)
  );

  axi_mem_array array_inst (
    .clk_i  (clk_i),
    .we_i   (mem_we),
    .waddr_i(mem_waddr),
    .wdata_i(mem_wdata),
    .wstrb_i(mem_wstrb),
    .re_i   (mem_re),
    .raddr_i(mem_raddr),
    .rdata_o(mem_rdata)
  );

endmodule

`default_nettype wire

// ==== hw/axi_mem_read_ctrl.sv ====
`default_nettype none

`include "axi_mem_consts.svh"

module axi_mem_read_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_empty_i,
  input  axi_mem_pkg::burst_req_t req_head_i,
  output logic                    req_pop_o,
  output logic                    r_valid_o,
  output axi_mem_pkg::data_t      r_data_o,
  output axi_mem_pkg::id_t        r_id_o,
  output axi_mem_pkg::resp_t      r_resp_o,
  output logic                    r_last_o,
  input  logic                    r_ready_i,
  output logic                    mem_re_o,
  output axi_mem_pkg::word_addr_t mem_raddr_o,
  input  axi_mem_pkg::data_t      mem_rdata_i
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {R_IDLE, R_READ, R_WAIT, R_PRESENT} state_t;

  state_t     state_q;
  id_t        id_q;
  data_t      r_data_q;
  logic       r_fire;
  logic       cnt_last;
  word_addr_t cnt_addr;

  assign req_pop_o = (state_q == R_IDLE) && !req_empty_i;
  assign r_valid_o = (state_q == R_PRESENT);
  assign r_fire    = r_valid_o && r_ready_i;

  axi_mem_beat_counter beat_counter_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .load_i      (req_pop_o),
    .start_addr_i(req_head_i.word_addr),
    .len_i       (req_head_i.len),
    .step_i      (r_fire && !cnt_last),
    .word_addr_o (cnt_addr),
    .last_o      (cnt_last)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= R_IDLE;
    end else begin
      case (state_q)
        R_IDLE:    if (req_pop_o) state_q <= R_READ;
        // Array output shows up one cycle after the enable
        R_READ:    state_q <= R_WAIT;
        R_WAIT:    state_q <= R_PRESENT;
        R_PRESENT: if (r_fire) state_q <= cnt_last ? R_IDLE : R_READ;
        default:   state_q <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_pop_o) id_q <= req_head_i.id;
    if (state_q == R_WAIT) r_data_q <= mem_rdata_i;
  end

  assign mem_re_o    = (state_q == R_READ);
  assign mem_raddr_o = cnt_addr;

  // Counter stays put while presenting, so its flag marks the final beat
  assign r_data_o = r_data_q;
  assign r_id_o   = id_q;
  assign r_resp_o = `AXI_MEM_RESP_OKAY;
  assign r_last_o = cnt_last;

  // R payload holds while the master stalls
  assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_id_o)
      && $stable(r_last_o))
    else $error("R payload changed while stalled");

endmodule

`default_nettype wire

// ==== hw/axi_mem_write_ctrl.sv ====
`default_nettype none

`include "axi_mem_consts.svh"

module axi_mem_write_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_empty_i,
  input  axi_mem_pkg::burst_req_t req_head_i,
  output logic                    req_pop_o,
  input  logic                    w_valid_i,
  input  axi_mem_pkg::data_t      w_data_i,
  input  axi_mem_pkg::strb_t      w_strb_i,
  input  logic                    w_last_i,
  output logic                    w_ready_o,
  output logic                    b_valid_o,
  output axi_mem_pkg::id_t        b_id_o,
  output axi_mem_pkg::resp_t      b_resp_o,
  input  logic                    b_ready_i,
  output logic                    mem_we_o,
  output axi_mem_pkg::word_addr_t mem_waddr_o,
  output axi_mem_pkg::data_t      mem_wdata_o,
  output axi_mem_pkg::strb_t      mem_wstrb_o
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} state_t;

  state_t     state_q;
  id_t        id_q;
  logic       mismatch_q;
  logic       w_fire;
  logic       cnt_last;
  word_addr_t cnt_addr;

  assign req_pop_o = (state_q == W_IDLE) && !req_empty_i;
  assign w_ready_o = (state_q == W_DATA);
  assign w_fire    = w_valid_i && w_ready_o;

  axi_mem_beat_counter beat_counter_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .load_i      (req_pop_o),
    .start_addr_i(req_head_i.word_addr),
    .len_i       (req_head_i.len),
    .step_i      (w_fire && !cnt_last),
    .word_addr_o (cnt_addr),
    .last_o      (cnt_last)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= W_IDLE;
      mismatch_q <= 1'b0;
    end else begin
      case (state_q)
        W_IDLE: if (req_pop_o) begin
          state_q    <= W_DATA;
          mismatch_q <= 1'b0;
        end
        W_DATA: if (w_fire) begin
          // Sticky, so one wrong beat taints the whole burst
          if (w_last_i != cnt_last) mismatch_q <= 1'b1;
          if (cnt_last) state_q <= W_RESP;
        end
        W_RESP: if (b_ready_i) state_q <= W_IDLE;
        default: state_q <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_pop_o) id_q <= req_head_i.id;
  end

  assign b_valid_o = (state_q == W_RESP);
  assign b_id_o    = id_q;
  assign b_resp_o  = mismatch_q ? `AXI_MEM_RESP_SLVERR : `AXI_MEM_RESP_OKAY;

  assign mem_we_o    = w_fire;
  assign mem_waddr_o = cnt_addr;
  assign mem_wdata_o = w_data_i;
  assign mem_wstrb_o = w_strb_i;

  // B payload holds while the master stalls
  assert property (@(posedge clk_i) disable iff (rst_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o) && $stable(b_resp_o))
    else $error("B payload changed while stalled");

endmodule

`default_nettype wire

// ==== hw/axi_mem_array.sv ====
`default_nettype none

`include "axi_mem_consts.svh"

module axi_mem_array (
  input  logic                    clk_i,
  input  logic                    we_i,
  input  axi_mem_pkg::word_addr_t waddr_i,
  input  axi_mem_pkg::data_t      wdata_i,
  input  axi_mem_pkg::strb_t      wstrb_i,
  input  logic                    re_i,
  input  axi_mem_pkg::word_addr_t raddr_i,
  output axi_mem_pkg::data_t      rdata_o
);
  import axi_mem_pkg::*;

  data_t mem [`AXI_MEM_WORDS];

  // Byte lanes are written independently
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) mem[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // Registered read, sees the old word when a write hits the same address
  always_ff @(posedge clk_i) begin
    if (re_i) rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

// ==== hw/axi_mem_beat_counter.sv ====
`default_nettype none

`include "axi_mem_consts.svh"

module axi_mem_beat_counter (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    load_i,
  input  axi_mem_pkg::word_addr_t start_addr_i,
  input  axi_mem_pkg::len_t       len_i,
  input  logic                    step_i,
  output axi_mem_pkg::word_addr_t word_addr_o,
  output logic                    last_o
);
  import axi_mem_pkg::*;

  word_addr_t addr_q;
  len_t       remaining_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      addr_q      <= '0;
      remaining_q <= '0;
    end else if (load_i) begin
      addr_q      <= start_addr_i;
      remaining_q <= len_i;
    end else if (step_i) begin
      // Bursts wrap around the end of the array
      addr_q      <= (addr_q == word_addr_t'(`AXI_MEM_WORDS - 1)) ? '0 : addr_q + 1'b1;
      remaining_q <= remaining_q - 1'b1;
    end
  end

  assign word_addr_o = addr_q;
  assign last_o      = (remaining_q == '0);

endmodule

`default_nettype wire

// ==== hw/axi_mem_req_fifo.sv ====
`default_nettype none

`include "axi_mem_consts.svh"

module axi_mem_req_fifo (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    push_i,
  input  axi_mem_pkg::burst_req_t push_data_i,
  output logic                    full_o,
  input  logic                    pop_i,
  output axi_mem_pkg::burst_req_t head_o,
  output logic                    empty_o
);
  import axi_mem_pkg::*;

  localparam int unsigned DEPTH = `AXI_MEM_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  burst_req_t       entries [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Circular increment, also correct for a depth that is not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);
  assign head_o  = entries[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) wr_ptr <= next_ptr(wr_ptr);
      if (pop_i) rd_ptr <= next_ptr(rd_ptr);
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) entries[wr_ptr] <= push_data_i;
  end

  // The top and the state machines must honour the flags
  assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o)
    else $error("Push into a full request queue");
  assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o)
    else $error("Pop from an empty request queue");

endmodule

`default_nettype wire

// ==== hw/axi_mem_pkg.sv ====
`default_nettype none

`include "axi_mem_consts.svh"

package axi_mem_pkg;

  localparam int unsigned STRB_W = `AXI_MEM_DATA_W / 8;
  localparam int unsigned BYTE_OFF_W = $clog2(STRB_W);
  localparam int unsigned WORD_ADDR_W = $clog2(`AXI_MEM_WORDS);

  typedef logic [`AXI_MEM_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_MEM_DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [`AXI_MEM_ID_W-1:0] id_t;
  typedef logic [`AXI_MEM_LEN_W-1:0] len_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [1:0] resp_t;

  // One accepted AW or AR request, already reduced to a word index
  typedef struct packed {
    id_t        id;
    word_addr_t word_addr;
    len_t       len;
  } burst_req_t;

endpackage

`default_nettype wire

// ==== hw/axi_mem_consts.svh ====
`ifndef AXI_MEM_CONSTS_SVH
`define AXI_MEM_CONSTS_SVH

// Bus widths
`define AXI_MEM_ADDR_W 16
`define AXI_MEM_DATA_W 32
`define AXI_MEM_ID_W 4
`define AXI_MEM_LEN_W 8

// Storage depth in data words, and request queue depth
`define AXI_MEM_WORDS 1024
`define AXI_MEM_FIFO_DEPTH 4

// AXI response codes
`define AXI_MEM_RESP_OKAY 2'd0
`define AXI_MEM_RESP_SLVERR 2'd2

`endif
